/* logic/blit_pkg.sv */
package blit_pkg;

    // widths with a meaning
    typedef logic [15:0] word_t;    // memory and register data
    typedef logic [15:0] addr_t;    // memory address
    typedef logic [3:0]  reg_num_t; // blit register number

    // blit register numbers
    localparam reg_num_t BLIT_MODE    = 4'd0;
    localparam reg_num_t BLIT_RD_MOD  = 4'd1;
    localparam reg_num_t BLIT_WR_MOD  = 4'd2;
    localparam reg_num_t BLIT_WR_MASK = 4'd3;
    localparam reg_num_t BLIT_WIDTH   = 4'd4;
    localparam reg_num_t BLIT_RD_ADDR = 4'd5;
    localparam reg_num_t BLIT_WR_ADDR = 4'd6;
    localparam reg_num_t BLIT_COUNT   = 4'd7;

    // MODE register fields
    localparam int MODE_RD_XR     = 15; // read from XR instead of VRAM
    localparam int MODE_WR_XR     = 14; // write to XR instead of VRAM
    localparam int MODE_FILL      = 13; // fill with RD_ADDR value
    localparam int MODE_SHIFT_MSB = 3;
    localparam int MODE_SHIFT_LSB = 0;

    // memory sizes, in address bits actually decoded
    localparam int VRAM_ADDR_W = 10;    // 1024 words
    localparam int XR_ADDR_W   = 8;     // 256 words

endpackage

/* logic/blitter.sv */
`timescale 1ns/100ps

module blitter import blit_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    // host register port
    input  logic     reg_wr_en_i,
    input  reg_num_t reg_num_i,
    input  word_t    reg_data_i,
    output word_t    reg_data_o,
    // status
    output logic     busy_o,
    output logic     full_o,
    output logic     done_intr_o,
    // memory bus
    output logic     vram_sel_o,
    output logic     xr_sel_o,
    output logic     wr_o,
    output logic [3:0] wr_mask_o,
    output addr_t    addr_o,
    output word_t    wdata_o,
    input  word_t    vram_rdata_i,
    input  logic     vram_ack_i,
    input  word_t    xr_rdata_i,
    input  logic     xr_ack_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP,
        ST_COPY_RD,
        ST_COPY_WR,
        ST_FILL_WR,
        ST_DONE
    } state_t;

    state_t state;

    // host visible registers
    logic       xreg_rd_xr;
    logic       xreg_wr_xr;
    logic       xreg_fill;
    logic [3:0] xreg_shift;
    word_t      xreg_rd_mod;
    word_t      xreg_wr_mod;
    word_t      xreg_wr_mask;
    word_t      xreg_width;
    addr_t      xreg_rd_addr;
    addr_t      xreg_wr_addr;
    word_t      xreg_count;
    logic       queued;

    // working copies, latched in setup
    logic        blit_rd_xr;
    logic        blit_wr_xr;
    addr_t       blit_rd_addr;
    addr_t       blit_wr_addr;
    logic [16:0] blit_count;     // bit 16 set on underflow

    logic  mem_ack;
    word_t mem_rdata;

    // only listen to the memory we selected
    assign mem_ack   = (vram_sel_o & vram_ack_i) | (xr_sel_o & xr_ack_i);
    assign mem_rdata = vram_sel_o ? vram_rdata_i : xr_rdata_i;

    assign busy_o      = (state != ST_IDLE);
    assign full_o      = queued;
    assign done_intr_o = (state == ST_DONE);

    // register writes and queue flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            xreg_rd_xr   <= 1'b0;
            xreg_wr_xr   <= 1'b0;
            xreg_fill    <= 1'b0;
            xreg_shift   <= '0;
            xreg_rd_mod  <= '0;
            xreg_wr_mod  <= '0;
            xreg_wr_mask <= 16'hFFFF;
            xreg_width   <= '0;
            xreg_rd_addr <= '0;
            xreg_wr_addr <= '0;
            xreg_count   <= '0;
            queued       <= 1'b0;
        end else begin
            if (state == ST_SETUP) begin
                queued <= 1'b0;     // a COUNT write below still wins
            end
            if (reg_wr_en_i) begin
                case (reg_num_i)
                    BLIT_MODE: begin
                        xreg_rd_xr <= reg_data_i[MODE_RD_XR];
                        xreg_wr_xr <= reg_data_i[MODE_WR_XR];
                        xreg_fill  <= reg_data_i[MODE_FILL];
                        xreg_shift <= reg_data_i[MODE_SHIFT_MSB:MODE_SHIFT_LSB];
                    end
                    BLIT_RD_MOD:  xreg_rd_mod  <= reg_data_i;
                    BLIT_WR_MOD:  xreg_wr_mod  <= reg_data_i;
                    BLIT_WR_MASK: xreg_wr_mask <= reg_data_i;
                    BLIT_WIDTH:   xreg_width   <= reg_data_i;
                    BLIT_RD_ADDR: xreg_rd_addr <= reg_data_i;
                    BLIT_WR_ADDR: xreg_wr_addr <= reg_data_i;
                    BLIT_COUNT: begin
                        xreg_count <= reg_data_i;
                        queued     <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // registered readback
    always_ff @(posedge clk) begin
        case (reg_num_i)
            BLIT_MODE:    reg_data_o <= {xreg_rd_xr, xreg_wr_xr, xreg_fill, 9'b0, xreg_shift};
            BLIT_RD_MOD:  reg_data_o <= xreg_rd_mod;
            BLIT_WR_MOD:  reg_data_o <= xreg_wr_mod;
            BLIT_WR_MASK: reg_data_o <= xreg_wr_mask;
            BLIT_WIDTH:   reg_data_o <= xreg_width;
            BLIT_RD_ADDR: reg_data_o <= xreg_rd_addr;
            BLIT_WR_ADDR: reg_data_o <= xreg_wr_addr;
            BLIT_COUNT:   reg_data_o <= xreg_count;
            default:      reg_data_o <= '0;     // 8..15 unimplemented
        endcase
    end

    // blit engine
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= ST_IDLE;
            vram_sel_o <= 1'b0;
            xr_sel_o   <= 1'b0;
            wr_o       <= 1'b0;
            wr_mask_o  <= 4'hF;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (queued) begin
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    blit_rd_xr <= xreg_rd_xr;
                    blit_wr_xr <= xreg_wr_xr;
                    wr_mask_o  <= xreg_wr_mask[3:0];
                    if (xreg_fill) begin
                        // first fill write goes out right away
                        vram_sel_o   <= ~xreg_wr_xr;
                        xr_sel_o     <= xreg_wr_xr;
                        wr_o         <= 1'b1;
                        addr_o       <= xreg_wr_addr;
                        wdata_o      <= xreg_rd_addr;  // fill value
                        blit_wr_addr <= xreg_wr_addr + 16'd1;
                        blit_count   <= {1'b0, xreg_count} - 17'd1;
                        state        <= ST_FILL_WR;
                    end else begin
                        vram_sel_o   <= ~xreg_rd_xr;
                        xr_sel_o     <= xreg_rd_xr;
                        wr_o         <= 1'b0;
                        addr_o       <= xreg_rd_addr;
                        blit_rd_addr <= xreg_rd_addr + 16'd1;
                        blit_wr_addr <= xreg_wr_addr;
                        blit_count   <= {1'b0, xreg_count};
                        state        <= ST_COPY_RD;
                    end
                end
                ST_COPY_RD: begin
                    if (mem_ack) begin
                        vram_sel_o   <= ~blit_wr_xr;
                        xr_sel_o     <= blit_wr_xr;
                        wr_o         <= 1'b1;
                        addr_o       <= blit_wr_addr;
                        wdata_o      <= mem_rdata;
                        blit_wr_addr <= blit_wr_addr + 16'd1;
                        blit_count   <= blit_count - 17'd1;
                        state        <= ST_COPY_WR;
                    end
                end
                ST_COPY_WR: begin
                    if (mem_ack) begin
                        if (blit_count[16]) begin
                            vram_sel_o <= 1'b0;
                            xr_sel_o   <= 1'b0;
                            wr_o       <= 1'b0;
                            state      <= ST_DONE;
                        end else begin
                            vram_sel_o   <= ~blit_rd_xr;
                            xr_sel_o     <= blit_rd_xr;
                            wr_o         <= 1'b0;
                            addr_o       <= blit_rd_addr;
                            blit_rd_addr <= blit_rd_addr + 16'd1;
                            state        <= ST_COPY_RD;
                        end
                    end
                end
                ST_FILL_WR: begin
                    if (mem_ack) begin
                        if (blit_count[16]) begin
                            vram_sel_o <= 1'b0;
                            xr_sel_o   <= 1'b0;
                            wr_o       <= 1'b0;
                            state      <= ST_DONE;
                        end else begin
                            addr_o       <= blit_wr_addr;   // select stays up
                            blit_wr_addr <= blit_wr_addr + 16'd1;
                            blit_count   <= blit_count - 17'd1;
                        end
                    end
                end
                ST_DONE: begin
                    state <= queued ? ST_SETUP : ST_IDLE;   // chain a queued blit
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/vram_ram.sv */
`timescale 1ns/100ps

module vram_ram import blit_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       sel_i,
    input  logic       wr_i,
    input  logic [3:0] wr_mask_i,
    input  addr_t      addr_i,
    input  word_t      wdata_i,
    output word_t      rdata_o,
    output logic       ack_o
);

    word_t mem [2**VRAM_ADDR_W];

    logic                   done_q;     // current access already acked
    addr_t                  last_addr;
    logic                   last_wr;
    logic                   start;
    logic [VRAM_ADDR_W-1:0] idx;

    assign idx   = addr_i[VRAM_ADDR_W-1:0];    // upper bits ignored
    assign start = sel_i && (!done_q || addr_i != last_addr || wr_i != last_wr);

    // array and read data
    always_ff @(posedge clk) begin
        if (start && wr_i) begin
            for (int n = 0; n < 4; n++) begin
                if (wr_mask_i[n]) begin
                    mem[idx][4*n +: 4] <= wdata_i[4*n +: 4];
                end
            end
        end
        rdata_o <= (start && !wr_i) ? mem[idx] : '0;  // zero outside ack
    end

    // one ack per access
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_o  <= start;
            done_q <= sel_i && (done_q || start);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            last_addr <= addr_i;
            last_wr   <= wr_i;
        end
    end

endmodule

/* logic/xr_ram.sv */
`timescale 1ns/100ps

module xr_ram import blit_pkg::*; (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  sel_i,
    input  logic  wr_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    output word_t rdata_o,
    output logic  ack_o
);

    word_t mem [2**XR_ADDR_W];

    logic [1:0]           stage_q;  // ack pipeline, bit 1 is the ack
    logic                 done_q;
    addr_t                last_addr;
    logic                 last_wr;
    logic                 start;
    logic [XR_ADDR_W-1:0] idx;

    assign idx   = addr_i[XR_ADDR_W-1:0];
    assign start = sel_i && (stage_q == 2'b00) &&
                   (!done_q || addr_i != last_addr || wr_i != last_wr);
    assign ack_o = stage_q[1];

    // access completes in second stage, whole words only
    always_ff @(posedge clk) begin
        if (stage_q[0] && wr_i) begin
            mem[idx] <= wdata_i;
        end
        rdata_o <= (stage_q[0] && !wr_i) ? mem[idx] : '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            stage_q <= 2'b00;
            done_q  <= 1'b0;
        end else begin
            stage_q <= {stage_q[0], start};
            done_q  <= sel_i && (done_q || start);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            last_addr <= addr_i;
            last_wr   <= wr_i;
        end
    end

endmodule

/* logic/blit_top.sv */
`timescale 1ns/100ps

module blit_top import blit_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    // host side
    input  logic       reg_wr_en_i,
    input  reg_num_t   reg_num_i,
    input  word_t      reg_data_i,
    output word_t      reg_data_o,
    output logic       busy_o,
    output logic       full_o,
    output logic       done_intr_o,
    // memory bus, exported for monitoring
    output logic       vram_sel_o,
    output logic       xr_sel_o,
    output logic       wr_o,
    output logic [3:0] wr_mask_o,
    output addr_t      addr_o,
    output word_t      wdata_o,
    output word_t      rdata_o,
    output logic       ack_o
);

    word_t vram_rdata;
    word_t xr_rdata;
    logic  vram_ack;
    logic  xr_ack;

    // both memories drive zero outside their ack
    assign rdata_o = vram_rdata | xr_rdata;
    assign ack_o   = vram_ack | xr_ack;

    blitter i_blitter (
        .clk          (clk),
        .reset_i      (reset_i),
        .reg_wr_en_i  (reg_wr_en_i),
        .reg_num_i    (reg_num_i),
        .reg_data_i   (reg_data_i),
        .reg_data_o   (reg_data_o),
        .busy_o       (busy_o),
        .full_o       (full_o),
        .done_intr_o  (done_intr_o),
        .vram_sel_o   (vram_sel_o),
        .xr_sel_o     (xr_sel_o),
        .wr_o         (wr_o),
        .wr_mask_o    (wr_mask_o),
        .addr_o       (addr_o),
        .wdata_o      (wdata_o),
        .vram_rdata_i (vram_rdata),
        .vram_ack_i   (vram_ack),
        .xr_rdata_i   (xr_rdata),
        .xr_ack_i     (xr_ack)
    );

    vram_ram i_vram_ram (
        .clk       (clk),
        .reset_i   (reset_i),
        .sel_i     (vram_sel_o),
        .wr_i      (wr_o),
        .wr_mask_i (wr_mask_o),
        .addr_i    (addr_o),
        .wdata_i   (wdata_o),
        .rdata_o   (vram_rdata),
        .ack_o     (vram_ack)
    );

    xr_ram i_xr_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .sel_i   (xr_sel_o),
        .wr_i    (wr_o),
        .addr_i  (addr_o),
        .wdata_i (wdata_o),
        .rdata_o (xr_rdata),
        .ack_o   (xr_ack)
    );

endmodule

/* verif/tb_blit_top.sv */
`timescale 1ns/100ps

module tb_blit_top import blit_pkg::*; ();

    localparam int VRAM_WORDS = 2**VRAM_ADDR_W;
    localparam int XR_WORDS   = 2**XR_ADDR_W;
    localparam int N_FILL     = 12;
    localparam int N_COPY     = 16;
    localparam int MAX_CNT    = 7;
    localparam int BLIT_LIMIT = 16 * (MAX_CNT + 1) + 64;  // cycles from COUNT write to done
    // preload, fills, copies, chained pair, final readback in chunks of 8
    localparam int N_BLITS = VRAM_WORDS + XR_WORDS + N_FILL + N_COPY + 2
                             + (XR_WORDS + VRAM_WORDS) / 8;
    localparam int N_WORDS = 2 * (VRAM_WORDS + XR_WORDS) + (N_FILL + N_COPY + 2) * (MAX_CNT + 1);
    localparam int CYCLE_LIMIT = N_WORDS * 8 + N_BLITS * 24 + 2000;

    logic       clk;
    logic       reset_i;
    logic       reg_wr_en;
    reg_num_t   reg_num;
    word_t      reg_wdata;
    word_t      reg_rdata;
    logic       busy;
    logic       full;
    logic       done_intr;
    logic       vram_sel;
    logic       xr_sel;
    logic       wr;
    logic [3:0] wr_mask;
    addr_t      addr;
    word_t      wdata;
    word_t      rdata;
    logic       ack;

    // reference memories
    word_t vram_model [VRAM_WORDS];
    word_t xr_model [XR_WORDS];

    // predicted writes, in bus order
    logic       exp_xr [$];
    addr_t      exp_addr [$];
    word_t      exp_data [$];
    logic [3:0] exp_mask [$];

    integer seed = 32'hed17482b;
    int errors = 0;
    int reads_checked = 0;
    int writes_checked = 0;
    int blits_issued = 0;
    int done_seen = 0;
    int cycle_count = 0;

    blit_top i_blit_top (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_en_i (reg_wr_en),
        .reg_num_i   (reg_num),
        .reg_data_i  (reg_wdata),
        .reg_data_o  (reg_rdata),
        .busy_o      (busy),
        .full_o      (full),
        .done_intr_o (done_intr),
        .vram_sel_o  (vram_sel),
        .xr_sel_o    (xr_sel),
        .wr_o        (wr),
        .wr_mask_o   (wr_mask),
        .addr_o      (addr),
        .wdata_o     (wdata),
        .rdata_o     (rdata),
        .ack_o       (ack)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
    end

    function automatic int rnd(input int n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t nibble_merge(input word_t old, input word_t data,
                                           input logic [3:0] mask);
        word_t res;
        res = old;
        for (int n = 0; n < 4; n++) begin
            if (mask[n]) begin
                res[4*n +: 4] = data[4*n +: 4];
            end
        end
        return res;
    endfunction

    task automatic show_mismatch(input string name, input word_t expected, input word_t actual);
        $display("ERROR %s: expected %h, actual %h at %0t", name, expected, actual, $time);
        errors++;
    endtask

    // watch every acknowledged access on the exported bus
    always @(negedge clk) begin : bus_monitor
        word_t      expected;
        logic       e_xr;
        addr_t      e_addr;
        word_t      e_data;
        logic [3:0] e_mask;
        if (done_intr) begin
            done_seen++;
        end
        if (ack && !reset_i) begin
            if (!wr) begin
                expected = xr_sel ? xr_model[addr[XR_ADDR_W-1:0]]
                                  : vram_model[addr[VRAM_ADDR_W-1:0]];
                if (rdata !== expected) begin
                    show_mismatch("rdata_o", expected, rdata);
                end
                reads_checked++;
            end else if (exp_addr.size() == 0) begin
                $display("write to address %h at %0t was not expected", addr, $time);
                errors++;
            end else begin
                e_xr   = exp_xr.pop_front();
                e_addr = exp_addr.pop_front();
                e_data = exp_data.pop_front();
                e_mask = exp_mask.pop_front();
                if (xr_sel !== e_xr) begin
                    show_mismatch("xr_sel_o", e_xr, xr_sel);
                end
                if (vram_sel !== !e_xr) begin
                    show_mismatch("vram_sel_o", !e_xr, vram_sel);
                end
                if (addr !== e_addr) begin
                    show_mismatch("addr_o", e_addr, addr);
                end
                if (wdata !== e_data) begin
                    show_mismatch("wdata_o", e_data, wdata);
                end
                if (wr_mask !== e_mask) begin
                    show_mismatch("wr_mask_o", e_mask, wr_mask);
                end
                if (e_xr) begin
                    xr_model[e_addr[XR_ADDR_W-1:0]] = e_data;   // XR ignores the mask
                end else begin
                    vram_model[e_addr[VRAM_ADDR_W-1:0]] =
                        nibble_merge(vram_model[e_addr[VRAM_ADDR_W-1:0]], e_data, e_mask);
                end
                writes_checked++;
            end
        end
    end

    task automatic write_reg(input reg_num_t num, input word_t data);
        @(negedge clk);
        reg_wr_en = 1'b1;
        reg_num   = num;
        reg_wdata = data;
        @(negedge clk);
        reg_wr_en = 1'b0;
    endtask

    task automatic check_reg(input reg_num_t num, input word_t expected);
        @(negedge clk);
        reg_num = num;
        @(negedge clk);     // readback is registered
        if (reg_rdata !== expected) begin
            show_mismatch($sformatf("reg_data_o (register %0d)", num), expected, reg_rdata);
        end
    endtask

    // program a blit, predict its writes, then queue it by writing COUNT
    task automatic start_blit(input logic fill, input logic rd_xr, input logic wr_xr,
                              input logic [3:0] mask, input addr_t rd_start,
                              input addr_t wr_start, input word_t cnt);
        word_t src;
        write_reg(BLIT_MODE, {rd_xr, wr_xr, fill, 13'(rnd(8192))});  // noise in shift bits
        write_reg(BLIT_WR_MASK, {12'(rnd(4096)), mask});
        write_reg(BLIT_RD_ADDR, rd_start);
        write_reg(BLIT_WR_ADDR, wr_start);
        for (int i = 0; i <= cnt; i++) begin
            if (fill) begin
                src = rd_start;
            end else if (rd_xr) begin
                src = xr_model[(rd_start + i) % XR_WORDS];
            end else begin
                src = vram_model[(rd_start + i) % VRAM_WORDS];
            end
            exp_xr.push_back(wr_xr);
            exp_addr.push_back(wr_start + addr_t'(i));
            exp_data.push_back(src);
            exp_mask.push_back(mask);
        end
        write_reg(BLIT_COUNT, cnt);
        blits_issued++;
    endtask

    // left is the number of predicted writes that belong to a queued blit
    task automatic wait_done(input int left);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done_intr && n < BLIT_LIMIT);
        if (!done_intr) begin
            $display("no done pulse within %0d cycles at %0t", BLIT_LIMIT, $time);
            errors++;
        end
        if (exp_addr.size() != left) begin
            $display("blit ended with %0d writes outstanding instead of %0d",
                     exp_addr.size(), left);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("blits %0d, done pulses %0d, reads checked %0d, writes checked %0d, errors %0d",
                 blits_issued, done_seen, reads_checked, writes_checked, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin : watchdog
        wait (cycle_count >= CYCLE_LIMIT);
        $display("run stopped at the limit of %0d cycles before the tests ended", CYCLE_LIMIT);
        errors++;
        finish_run();
    end

    initial begin : main
        word_t want [16];
        word_t data;
        word_t cnt;
        addr_t rd_start;
        addr_t wr_start;
        logic  rd_xr;
        logic  wr_xr;
        int    n;
        reset_i   = 1'b1;
        reg_wr_en = 1'b0;
        reg_num   = '0;
        reg_wdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        if ({busy, full, done_intr, vram_sel, xr_sel, wr} !== 6'b0) begin
            show_mismatch("{busy_o,full_o,done_intr_o,vram_sel_o,xr_sel_o,wr_o}", 16'h0,
                          {busy, full, done_intr, vram_sel, xr_sel, wr});
        end
        for (int r = 0; r < 16; r++) begin
            check_reg(reg_num_t'(r), (r == BLIT_WR_MASK) ? 16'hFFFF : 16'h0000);
        end

        // register bank, COUNT is left to the blits
        for (int pass = 0; pass < 3; pass++) begin
            for (int r = 0; r < 16; r++) begin
                data = 16'(rnd(65536));
                if (r != BLIT_COUNT) begin
                    write_reg(reg_num_t'(r), data);
                end
                if (r == BLIT_MODE) begin
                    want[r] = data & 16'hE00F;
                end else if (r == BLIT_COUNT || r >= 8) begin
                    want[r] = 16'h0000;
                end else begin
                    want[r] = data;
                end
            end
            for (int r = 0; r < 16; r++) begin
                check_reg(reg_num_t'(r), want[r]);
            end
        end

        // known contents, one word per fill
        for (int a = 0; a < VRAM_WORDS; a++) begin
            start_blit(1'b1, 1'b0, 1'b0, 4'hF, 16'(a) * 16'h9e37 ^ 16'h5c21, addr_t'(a), 16'd0);
            wait_done(0);
        end
        for (int a = 0; a < XR_WORDS; a++) begin
            start_blit(1'b1, 1'b0, 1'b1, 4'hF, {8'(a) ^ 8'h3c, ~8'(a)}, addr_t'(a), 16'd0);
            wait_done(0);
        end

        for (int k = 0; k < N_FILL; k++) begin
            wr_xr    = k[0];
            cnt      = 16'(rnd(MAX_CNT + 1));
            wr_start = wr_xr ? 16'(rnd(XR_WORDS - MAX_CNT)) : 16'(rnd(VRAM_WORDS - MAX_CNT));
            start_blit(1'b1, 1'b0, wr_xr, 4'(rnd(16)), 16'(rnd(65536)), wr_start, cnt);
            check_reg(BLIT_COUNT, cnt);
            wait_done(0);
        end

        // source in the low half, destination in the high half
        for (int k = 0; k < N_COPY; k++) begin
            rd_xr    = k[0];
            wr_xr    = k[1];
            cnt      = 16'(rnd(MAX_CNT + 1));
            rd_start = rd_xr ? 16'(rnd(XR_WORDS / 2 - MAX_CNT))
                             : 16'(rnd(VRAM_WORDS / 2 - MAX_CNT));
            wr_start = wr_xr ? 16'(XR_WORDS / 2 + rnd(XR_WORDS / 2 - MAX_CNT))
                             : 16'(VRAM_WORDS / 2 + rnd(VRAM_WORDS / 2 - MAX_CNT));
            start_blit(1'b0, rd_xr, wr_xr, 4'(rnd(16)), rd_start, wr_start, cnt);
            wait_done(0);
        end

        // second blit queued behind a running copy
        start_blit(1'b0, 1'b0, 1'b1, 4'hF, 16'd40, 16'd200, 16'd7);
        n = 0;
        while (!(busy && !full) && n < 20) begin
            @(negedge clk);
            n++;
        end
        start_blit(1'b1, 1'b0, 1'b0, 4'(rnd(16)), 16'(rnd(65536)), 16'd700, 16'd3);
        if ({busy, full} !== 2'b11) begin
            show_mismatch("{busy_o,full_o}", 16'h3, {busy, full});
        end
        wait_done(4);
        @(negedge clk);
        if (busy !== 1'b1) begin
            show_mismatch("busy_o", 16'h1, busy);   // went idle between chained blits
        end
        wait_done(0);

        // every XR word through VRAM, then every VRAM word through XR
        for (int k = 0; k < XR_WORDS / 8; k++) begin
            // mask off so VRAM keeps its words for the second pass
            start_blit(1'b0, 1'b1, 1'b0, 4'h0, 16'(8 * k), 16'(8 * k), 16'd7);
            wait_done(0);
        end
        for (int k = 0; k < VRAM_WORDS / 8; k++) begin
            start_blit(1'b0, 1'b0, 1'b1, 4'hF, 16'(8 * k), 16'((8 * k) % XR_WORDS), 16'd7);
            wait_done(0);
        end

        repeat (2) @(negedge clk);
        if (done_seen != blits_issued) begin
            $display("saw %0d done pulses for %0d blits", done_seen, blits_issued);
            errors++;
        end
        finish_run();
    end

endmodule

/* vlog.f */
logic/blit_pkg.sv
logic/blitter.sv
logic/vram_ram.sv
logic/xr_ram.sv
logic/blit_top.sv
verif/tb_blit_top.sv

/* Bender.yml */
package:
  name: blit_top

sources:
  - logic/blit_pkg.sv
  - logic/blitter.sv
  - logic/vram_ram.sv
  - logic/xr_ram.sv
  - logic/blit_top.sv
  - target: simulation
    files:
      - verif/tb_blit_top.sv
